// File: verilog/cpu_isa_pkg.sv
// instruction set package: word types, instruction fields, opcodes and ALU functions
`default_nettype none

package cpu_isa_pkg;

    ////////////////////////////////
    // words and registers
    ////////////////////////////////
    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 4;
    localparam int NUM_REGS  = 16;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    ////////////////////////////////
    // instruction fields
    ////////////////////////////////
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 24;
    localparam int RD_MSB  = 23;   // store: data source
    localparam int RD_LSB  = 20;
    localparam int RS_MSB  = 19;   // base reg for load/store
    localparam int RS_LSB  = 16;
    localparam int RT_MSB  = 15;
    localparam int RT_LSB  = 12;
    localparam int IMM_MSB = 15;   // sign extended to a word
    localparam int IMM_LSB = 0;
    localparam int IMM_W   = IMM_MSB - IMM_LSB + 1;

    // unlisted codes decode as nop
    typedef enum logic [7:0] {
        op_nop   = 8'h00,
        op_add   = 8'h01,
        op_sub   = 8'h02,
        op_and   = 8'h03,
        op_or    = 8'h04,
        op_xor   = 8'h05,
        op_addi  = 8'h11,
        op_load  = 8'h81,
        op_store = 8'h83
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass
    } alu_op_t;

    localparam int IMEM_DEPTH = 64;

endpackage

`default_nettype wire

// File: verilog/cpu_bus_pkg.sv
// bus package: address map, data memory geometry and host-write credit types
`default_nettype none

package cpu_bus_pkg;

    localparam int ADDR_W = 16;
    typedef logic [ADDR_W-1:0] addr_t;

    // stores at or above this go out on the host port
    localparam addr_t HOST_BASE = 16'h9000;

    ////////////////////////////////
    // data memory
    ////////////////////////////////
    localparam int DMEM_DEPTH   = 256;
    localparam int DMEM_IDX_MSB = 9;
    localparam int DMEM_IDX_LSB = 2;   // word aligned

    // host-write flow control
    localparam int HOST_CREDITS = 2;
    typedef logic [1:0] credit_t;

    localparam int IMEM_IDX_W = 6;
    typedef logic [IMEM_IDX_W-1:0] imem_idx_t;

endpackage

`default_nettype wire

// File: verilog/cpu_decode.sv
// decode stage with register file, control decode and read-after-write interlock
`timescale 1ns/1ps
`default_nettype none

module cpu_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_valid,
    input  cpu_isa_pkg::word_t    fetch_instr,
    input  logic                  freeze,
    input  logic                  wb_en,
    input  cpu_isa_pkg::reg_idx_t wb_idx,
    input  cpu_isa_pkg::word_t    wb_data,
    output logic                  hazard_stall,
    output logic                  dx_valid,
    output cpu_isa_pkg::alu_op_t  dx_op,
    output cpu_isa_pkg::word_t    dx_a,
    output cpu_isa_pkg::word_t    dx_b,
    output cpu_isa_pkg::word_t    dx_imm,
    output logic                  dx_use_imm,
    output cpu_isa_pkg::reg_idx_t dx_rd,
    output logic                  dx_wr_en,
    output logic                  dx_mem_rd,
    output logic                  dx_mem_wr
);
    import cpu_isa_pkg::*;

    word_t    regs [NUM_REGS];
    opcode_t  opc;
    reg_idx_t rd, rs, rt, src2;
    word_t    rd_a, rd_b, imm_ext;
    alu_op_t  op;
    logic     use_imm, wr_en, mem_rd, mem_wr;
    logic     use_rs, use_src2;

    assign opc     = opcode_t'(fetch_instr[OPC_MSB:OPC_LSB]);
    assign rd      = fetch_instr[RD_MSB:RD_LSB];
    assign rs      = fetch_instr[RS_MSB:RS_LSB];
    assign rt      = fetch_instr[RT_MSB:RT_LSB];
    assign src2    = (opc == op_store) ? rd : rt;   // store data comes from rd
    assign imm_ext = {{(WORD_W-IMM_W){fetch_instr[IMM_MSB]}}, fetch_instr[IMM_MSB:IMM_LSB]};

    // write-through read ports
    assign rd_a = (wb_en && wb_idx == rs) ? wb_data : regs[rs];
    assign rd_b = (wb_en && wb_idx == src2) ? wb_data : regs[src2];

    always_comb begin
        use_imm  = 1'b0;
        wr_en    = 1'b0;
        mem_rd   = 1'b0;
        mem_wr   = 1'b0;
        use_rs   = 1'b1;
        use_src2 = 1'b0;
        case (opc)
            op_add, op_sub, op_and, op_or, op_xor: begin
                wr_en    = 1'b1;
                use_src2 = 1'b1;
            end
            op_addi, op_load: begin
                use_imm = 1'b1;
                wr_en   = 1'b1;
                mem_rd  = (opc == op_load);
            end
            op_store: begin
                use_imm  = 1'b1;
                use_src2 = 1'b1;
                mem_wr   = 1'b1;
            end
            default: use_rs = 1'b0;   // nop reads nothing
        endcase
        case (opc)
            op_add, op_addi, op_load, op_store: op = alu_add;
            op_sub:  op = alu_sub;
            op_and:  op = alu_and;
            op_or:   op = alu_or;
            op_xor:  op = alu_xor;
            default: op = alu_pass;
        endcase
    end

    // the producer sits in execute, its value is written through one cycle later
    assign hazard_stall = fetch_valid && dx_valid && dx_wr_en &&
                          ((use_rs && dx_rd == rs) || (use_src2 && dx_rd == src2));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wb_en) begin
            regs[wb_idx] <= wb_data;
        end
    end

    ////////////////////////////////
    // decode to execute register
    ////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dx_valid  <= 1'b0;
            dx_wr_en  <= 1'b0;
            dx_mem_rd <= 1'b0;
            dx_mem_wr <= 1'b0;
        end else if (!freeze) begin
            dx_valid  <= fetch_valid && !hazard_stall;   // bubble while stalled
            dx_wr_en  <= wr_en;
            dx_mem_rd <= mem_rd;
            dx_mem_wr <= mem_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            dx_op      <= op;
            dx_a       <= rd_a;
            dx_b       <= rd_b;
            dx_imm     <= imm_ext;
            dx_use_imm <= use_imm;
            dx_rd      <= rd;
        end
    end

    // one stall per dependence, the producer writes back right after it
    a_stall_wb: assert property (@(posedge clk) disable iff (!rst_n)
        hazard_stall && !freeze |=> wb_en && wb_idx == $past(dx_rd));

endmodule

`default_nettype wire

// File: verilog/cpu_execute.sv
// execute stage: operand select, ALU and execute-to-result register
`timescale 1ns/1ps
`default_nettype none

module cpu_execute (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  freeze,
    input  logic                  dx_valid,
    input  cpu_isa_pkg::alu_op_t  dx_op,
    input  cpu_isa_pkg::word_t    dx_a,
    input  cpu_isa_pkg::word_t    dx_b,
    input  cpu_isa_pkg::word_t    dx_imm,
    input  logic                  dx_use_imm,
    input  cpu_isa_pkg::reg_idx_t dx_rd,
    input  logic                  dx_wr_en,
    input  logic                  dx_mem_rd,
    input  logic                  dx_mem_wr,
    output logic                  xr_valid,
    output cpu_isa_pkg::word_t    xr_result,
    output cpu_isa_pkg::word_t    xr_store_data,
    output cpu_isa_pkg::reg_idx_t xr_rd,
    output logic                  xr_wr_en,
    output logic                  xr_mem_rd,
    output logic                  xr_mem_wr
);
    import cpu_isa_pkg::*;

    word_t op_b;
    word_t alu_out;

    assign op_b = dx_use_imm ? dx_imm : dx_b;

    // load/store address is rs + imm through alu_add
    always_comb begin
        case (dx_op)
            alu_add: alu_out = dx_a + op_b;
            alu_sub: alu_out = dx_a - op_b;
            alu_and: alu_out = dx_a & op_b;
            alu_or:  alu_out = dx_a | op_b;
            alu_xor: alu_out = dx_a ^ op_b;
            default: alu_out = op_b;
        endcase
    end

    ////////////////////////////////
    // execute to result register
    ////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xr_valid  <= 1'b0;
            xr_wr_en  <= 1'b0;
            xr_mem_rd <= 1'b0;
            xr_mem_wr <= 1'b0;
        end else if (!freeze) begin
            xr_valid  <= dx_valid;
            xr_wr_en  <= dx_wr_en;
            xr_mem_rd <= dx_mem_rd;
            xr_mem_wr <= dx_mem_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            xr_result     <= alu_out;
            xr_store_data <= dx_b;   // rd value for stores
            xr_rd         <= dx_rd;
        end
    end

endmodule

`default_nettype wire

// File: verilog/cpu_result.sv
// result stage: data memory, host-write credit counter and register writeback
`timescale 1ns/1ps
`default_nettype none

module cpu_result (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  xr_valid,
    input  cpu_isa_pkg::word_t    xr_result,
    input  cpu_isa_pkg::word_t    xr_store_data,
    input  cpu_isa_pkg::reg_idx_t xr_rd,
    input  logic                  xr_wr_en,
    input  logic                  xr_mem_rd,
    input  logic                  xr_mem_wr,
    input  logic                  host_credit,
    output logic                  freeze,
    output logic                  wb_en,
    output cpu_isa_pkg::reg_idx_t wb_idx,
    output cpu_isa_pkg::word_t    wb_data,
    output logic                  host_valid,
    output cpu_bus_pkg::addr_t    host_addr,
    output cpu_isa_pkg::word_t    host_data
);
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;

    word_t                              dmem [DMEM_DEPTH];
    logic [DMEM_DEPTH-1:0]              dmem_written;   // unwritten words read as zero
    logic [DMEM_IDX_MSB-DMEM_IDX_LSB:0] dmem_idx;
    credit_t                            credit_cnt;
    addr_t                              addr;
    word_t                              load_data;
    logic                               in_host, host_hit, have_credit;

    assign addr        = xr_result[ADDR_W-1:0];
    assign dmem_idx    = addr[DMEM_IDX_MSB:DMEM_IDX_LSB];
    assign in_host     = (addr >= HOST_BASE);
    assign host_hit    = xr_valid && xr_mem_wr && in_host;
    assign have_credit = (credit_cnt != '0);

    ////////////////////////////////
    // host write port
    ////////////////////////////////
    assign host_valid = host_hit && have_credit;
    assign freeze     = host_hit && !have_credit;   // hold the pipe until a credit returns
    assign host_addr  = addr;
    assign host_data  = xr_store_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            credit_cnt <= credit_t'(HOST_CREDITS);
        else if (host_valid && !host_credit)
            credit_cnt <= credit_cnt - 1'b1;
        else if (host_credit && !host_valid)
            credit_cnt <= credit_cnt + 1'b1;
    end

    // local data memory, host region excluded
    always_ff @(posedge clk) begin
        if (xr_valid && xr_mem_wr && !in_host)
            dmem[dmem_idx] <= xr_store_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            dmem_written <= '0;
        else if (xr_valid && xr_mem_wr && !in_host)
            dmem_written[dmem_idx] <= 1'b1;
    end

    assign load_data = (in_host || !dmem_written[dmem_idx]) ? '0 : dmem[dmem_idx];

    // writeback
    assign wb_en   = xr_valid && xr_wr_en;
    assign wb_idx  = xr_rd;
    assign wb_data = xr_mem_rd ? load_data : xr_result;

    // host returns no more credits than it was handed, count never wraps
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= credit_t'(HOST_CREDITS));

    // a blocked host store stays put until it issues
    a_freeze_hold: assert property (@(posedge clk) disable iff (!rst_n)
        freeze |=> host_hit && $stable(host_addr) && $stable(host_data));

endmodule

`default_nettype wire

// File: verilog/cpu_core.sv
// core top level: run control, program counter, instruction memory and pipeline stages
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  load_en,
    input  cpu_bus_pkg::imem_idx_t load_idx,
    input  cpu_isa_pkg::word_t    load_data,
    input  logic                  host_credit,
    output logic                  host_valid,
    output cpu_bus_pkg::addr_t    host_addr,
    output cpu_isa_pkg::word_t    host_data
);
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;

    word_t               imem [IMEM_DEPTH];
    imem_idx_t           pc;
    logic [IMEM_IDX_W:0] prog_len;   // highest loaded index + 1
    logic                running, pc_done, in_prog, fetch_go;
    logic                fetch_valid, hazard_stall, freeze;
    word_t               fetch_instr;
    logic                dx_valid, dx_use_imm, dx_wr_en, dx_mem_rd, dx_mem_wr;
    alu_op_t             dx_op;
    word_t               dx_a, dx_b, dx_imm;
    reg_idx_t            dx_rd, xr_rd, wb_idx;
    logic                xr_valid, xr_wr_en, xr_mem_rd, xr_mem_wr, wb_en;
    word_t               xr_result, xr_store_data, wb_data;

    assign in_prog  = !pc_done && ({1'b0, pc} < prog_len);
    assign fetch_go = running && !hazard_stall && !freeze;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running     <= 1'b0;
            prog_len    <= '0;
            pc          <= '0;
            pc_done     <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            if (start)
                running <= 1'b1;   // stays in run until reset
            if (load_en && {1'b0, load_idx} >= prog_len)
                prog_len <= {1'b0, load_idx} + 1'b1;
            if (fetch_go) begin
                fetch_valid <= in_prog;
                if (in_prog) begin
                    pc      <= pc + 1'b1;
                    pc_done <= (pc == '1);   // no wrap back to zero
                end
            end
        end
    end

    // sync read, zeros past the program
    always_ff @(posedge clk) begin
        if (load_en)
            imem[load_idx] <= load_data;
        if (fetch_go)
            fetch_instr <= in_prog ? imem[pc] : '0;
    end

    cpu_decode  u_decode  (.*);
    cpu_execute u_execute (.*);
    cpu_result  u_result  (.*);

    a_load_idle: assert property (@(posedge clk) disable iff (!rst_n)
        load_en |-> !running);

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
// testbench clock source, 10 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);
    localparam int HALF_PERIOD = 5;

    initial clk = 1'b0;
    always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// File: test/cpu_core_tb.sv
// testbench for the pipelined core: program table, host-write credit model and checks
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb;
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;

    localparam int    NUM_TESTS = 4;
    localparam int    MAX_INSTR = 16;
    localparam int    MAX_WR    = 6;
    localparam int    TIMEOUT   = 500;
    localparam int    CR_PROMPT = 0;
    localparam int    CR_RANDOM = 1;
    localparam int    CR_HOLD   = 2;
    localparam word_t VAL_A     = 32'h0000_0123;
    localparam word_t VAL_B     = 32'hFFFF_FF0F;   // addi 16'hff0f, sign extended

    logic      clk, rst_n, start, load_en, host_credit, host_valid;
    imem_idx_t load_idx;
    word_t     load_data, host_data;
    addr_t     host_addr;

    ////////////////////////////////
    // test table
    ////////////////////////////////
    word_t prog_tbl [NUM_TESTS][MAX_INSTR];
    int    prog_len_tbl [NUM_TESTS];
    addr_t exp_addr [NUM_TESTS][MAX_WR];
    word_t exp_data [NUM_TESTS][MAX_WR];
    int    exp_cnt [NUM_TESTS];
    int    mode_tbl [NUM_TESTS];
    string name_tbl [NUM_TESTS];

    addr_t got_addr [$];   // host writes in arrival order
    word_t got_data [$];
    int    owed;
    logic  withhold, random_delay;
    int    err_cnt, tests_run, tests_failed;

    tb_clock_gen u_clock_gen (.clk(clk));
    cpu_core     u_cpu_core (.*);

    function automatic word_t encode_reg(opcode_t op, reg_idx_t rd,
                                         reg_idx_t rs, reg_idx_t rt);
        return {op, rd, rs, rt, 12'h000};
    endfunction

    function automatic word_t encode_imm(opcode_t op, reg_idx_t rd,
                                         reg_idx_t rs, logic [15:0] imm);
        return {op, rd, rs, imm};
    endfunction

    task automatic add_instr(input int t, input word_t w);
        prog_tbl[t][prog_len_tbl[t]] = w;
        prog_len_tbl[t]++;
    endtask

    task automatic add_write(input int t, input addr_t a, input word_t d);
        exp_addr[t][exp_cnt[t]] = a;
        exp_data[t][exp_cnt[t]] = d;
        exp_cnt[t]++;
    endtask

    task automatic build_table();
        name_tbl[0] = "alu operations";
        mode_tbl[0] = CR_RANDOM;
        add_instr(0, encode_imm(op_addi, 4'd1, 4'd0, 16'h0123));
        add_instr(0, encode_imm(op_addi, 4'd2, 4'd0, 16'hFF0F));
        add_instr(0, encode_reg(op_add, 4'd3, 4'd1, 4'd2));
        add_instr(0, encode_reg(op_sub, 4'd4, 4'd1, 4'd2));
        add_instr(0, encode_reg(op_and, 4'd5, 4'd1, 4'd2));
        add_instr(0, encode_reg(op_or, 4'd6, 4'd1, 4'd2));
        add_instr(0, encode_reg(op_xor, 4'd7, 4'd1, 4'd2));
        // r3..r7 out to 0x9000.. (imm sign extends, low 16 bits are the address)
        for (int r = 0; r < 5; r++)
            add_instr(0, encode_imm(op_store, reg_idx_t'(r + 3), 4'd0, 16'h9000 + 16'(r * 4)));
        add_write(0, 16'h9000, VAL_A + VAL_B);
        add_write(0, 16'h9004, VAL_A - VAL_B);
        add_write(0, 16'h9008, VAL_A & VAL_B);
        add_write(0, 16'h900C, VAL_A | VAL_B);
        add_write(0, 16'h9010, VAL_A ^ VAL_B);

        name_tbl[1] = "interlock chain";
        mode_tbl[1] = CR_PROMPT;
        add_instr(1, encode_imm(op_addi, 4'd1, 4'd1, 16'd5));
        add_instr(1, encode_imm(op_addi, 4'd1, 4'd1, 16'd7));
        add_instr(1, encode_imm(op_addi, 4'd1, 4'd1, 16'hFFFD));   // -3
        add_instr(1, encode_imm(op_addi, 4'd1, 4'd1, 16'd100));
        add_instr(1, encode_imm(op_store, 4'd1, 4'd0, 16'h9020));
        add_write(1, 16'h9020, 32'd5 + 32'd7 - 32'd3 + 32'd100);

        name_tbl[2] = "data memory";
        mode_tbl[2] = CR_RANDOM;
        add_instr(2, encode_imm(op_addi, 4'd1, 4'd0, 16'h8001));
        add_instr(2, encode_imm(op_addi, 4'd2, 4'd0, 16'h0100));
        add_instr(2, encode_imm(op_store, 4'd1, 4'd2, 16'h0008));
        add_instr(2, encode_imm(op_load, 4'd4, 4'd2, 16'h0008));
        add_instr(2, encode_imm(op_store, 4'd4, 4'd0, 16'h9030));
        add_instr(2, encode_imm(op_load, 4'd5, 4'd2, 16'h000C));   // never written
        add_instr(2, encode_imm(op_store, 4'd5, 4'd0, 16'h9034));
        add_write(2, 16'h9030, 32'hFFFF_8001);
        add_write(2, 16'h9034, 32'h0000_0000);

        name_tbl[3] = "credit back-pressure";
        mode_tbl[3] = CR_HOLD;
        for (int r = 1; r <= 4; r++)
            add_instr(3, encode_imm(op_addi, reg_idx_t'(r), 4'd0, 16'(r * 11)));
        for (int r = 1; r <= 4; r++)
            add_instr(3, encode_imm(op_store, reg_idx_t'(r), 4'd0, 16'h903C + 16'(r * 4)));
        for (int r = 1; r <= 4; r++)
            add_write(3, 16'h903C + 16'(r * 4), 32'(r * 11));
    endtask

    ////////////////////////////////
    // compare tasks
    ////////////////////////////////
    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_cnt == errs_before) begin
            $display("test %0d %s: pass", tests_run - 1, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED, %0d errors", tests_run - 1, name,
                     err_cnt - errs_before);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n   = 1'b0;
        start   = 1'b0;
        load_en = 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_flag("host_valid", host_valid, 1'b0);
            @(posedge clk);
        end
        #1;
        rst_n = 1'b1;
    endtask

    task automatic load_program(input int t);
        for (int i = 0; i < prog_len_tbl[t]; i++) begin
            @(posedge clk);
            #1;
            load_en   = 1'b1;
            load_idx  = imem_idx_t'(i);
            load_data = prog_tbl[t][i];
        end
        @(posedge clk);
        #1;
        load_en = 1'b0;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_writes(input int n);
        int cycles;
        cycles = 0;
        while (got_addr.size() < n && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (got_addr.size() < n) begin
            $display("timeout: only %0d of %0d host writes arrived", got_addr.size(), n);
            err_cnt++;
        end
    endtask

    task automatic check_idle();
        int errs_before;
        errs_before = err_cnt;
        apply_reset();
        load_program(0);   // host stores loaded, but no start
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_flag("host_valid", host_valid, 1'b0);
        end
        report_test("reset and idle", errs_before);
    endtask

    task automatic run_test(input int t);
        int errs_before;
        errs_before  = err_cnt;
        withhold     = (mode_tbl[t] == CR_HOLD);
        random_delay = (mode_tbl[t] == CR_RANDOM);
        apply_reset();
        load_program(t);
        pulse_start();
        if (withhold) begin
            repeat (100) @(posedge clk);
            if (got_addr.size() != HOST_CREDITS) begin
                $display("wrong number of host writes with credits withheld: %0d",
                         got_addr.size());
                err_cnt++;
            end
            withhold = 1'b0;   // host hands credits back
        end
        wait_writes(exp_cnt[t]);
        repeat (10) @(posedge clk);   // room for a stray extra write
        if (got_addr.size() != exp_cnt[t]) begin
            $display("wrong number of host writes: %0d, expected %0d",
                     got_addr.size(), exp_cnt[t]);
            err_cnt++;
        end
        for (int i = 0; i < exp_cnt[t] && i < got_addr.size(); i++) begin
            check_addr("host_addr", got_addr[i], exp_addr[t][i]);
            check_word("host_data", got_data[i], exp_data[t][i]);
        end
        report_test(name_tbl[t], errs_before);
    endtask

    ////////////////////////////////
    // host model: collects writes, returns credits
    ////////////////////////////////
    initial begin : credit_model
        int wait_left;
        void'($urandom(32'he7e5));
        host_credit = 1'b0;
        wait_left   = 0;
        forever begin
            @(negedge clk);
            if (!rst_n) begin
                owed      = 0;
                wait_left = 0;
                got_addr.delete();
                got_data.delete();
            end else if (host_valid) begin
                got_addr.push_back(host_addr);
                got_data.push_back(host_data);
                owed++;
            end
            @(posedge clk);
            #1;
            host_credit = 1'b0;
            if (rst_n && owed > 0 && !withhold) begin
                if (wait_left > 0) begin
                    wait_left--;
                end else begin
                    host_credit = 1'b1;   // one credit per pulse
                    owed--;
                    wait_left = random_delay ? int'($urandom_range(6, 0)) : 0;
                end
            end
        end
    end

    initial begin : main
        rst_n        = 1'b0;
        start        = 1'b0;
        load_en      = 1'b0;
        load_idx     = '0;
        load_data    = '0;
        withhold     = 1'b0;
        random_delay = 1'b0;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        build_table();
        check_idle();
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);
        $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
verilog/cpu_isa_pkg.sv
verilog/cpu_bus_pkg.sv
verilog/cpu_decode.sv
verilog/cpu_execute.sv
verilog/cpu_result.sv
verilog/cpu_core.sv
test/tb_clock_gen.sv
test/cpu_core_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
LINT     := --lint-only --timing
TOP      := cpu_core_tb
FILELIST := filelist.f
OBJ      := obj_dir
LOG      := sim.log
PASS_MSG := No errors

SRCS := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ)/V$(TOP): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ) -f $(FILELIST)

run: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ) $(LOG)
